//--- flist.f
+incdir+include
hdl/vbank_pkg.sv
hdl/data_bank.sv
hdl/cache_bank.sv
hdl/map_table.sv
hdl/port_scheduler.sv
hdl/read_return.sv
hdl/vbank_mem_1rw1w.sv
tests/vbank_mem_assertions.sv
tests/tb_vbank_mem.sv

//--- hdl/cache_bank.sv
`timescale 1ns/1ps
`default_nettype none

module cache_bank
  import vbank_pkg::*;
(
  input  logic               clk,
  input  logic               write,
  input  logic [BITVROW-1:0] wr_row,
  input  logic [WIDTH-1:0]   din,
  input  logic [BITVROW-1:0] rd_row_a,
  input  logic [BITVROW-1:0] rd_row_b,
  output logic [WIDTH-1:0]   dout_a,
  output logic [WIDTH-1:0]   dout_b
);

  // one spare word per row, shared by all banks.
  logic [WIDTH-1:0] mem [NUMVROW];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_row] <= din;
    end
  end

  assign dout_a = mem[rd_row_a]; // eviction read.
  assign dout_b = mem[rd_row_b]; // port 0 read.

endmodule

`default_nettype wire

//--- hdl/data_bank.sv
`timescale 1ns/1ps
`default_nettype none

module data_bank
  import vbank_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               read,
  input  logic               write,
  input  logic [BITVROW-1:0] row,
  input  logic [WIDTH-1:0]   din,
  output logic [WIDTH-1:0]   dout
);

  logic [WIDTH-1:0] mem [NUMVROW];
  logic [WIDTH-1:0] rd_pipe [READ_DELAY];

  always_ff @(posedge clk) begin
    if (write && !rst) begin
      mem[row] <= din; // no stores while in reset.
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_pipe[0] <= mem[row]; // old word on a same-edge write.
    end
    for (int i = 1; i < READ_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[READ_DELAY-1];

endmodule

`default_nettype wire

//--- hdl/map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table
  import vbank_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               set,
  input  logic [BITVROW-1:0] set_row,
  input  logic [BITVBNK-1:0] set_bank,
  input  logic               clr0,
  input  logic [BITVROW-1:0] clr0_row,
  input  logic               clr1,
  input  logic [BITVROW-1:0] clr1_row,
  input  logic [BITVROW-1:0] look_row0,
  input  logic [BITVROW-1:0] look_row1,
  output logic               look_vld0,
  output logic [BITVBNK-1:0] look_bank0,
  output logic               look_vld1,
  output logic [BITVBNK-1:0] look_bank1
);

  logic [NUMVROW-1:0] vld_q;
  logic [BITVBNK-1:0] bank_q [NUMVROW];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      if (clr0) begin
        vld_q[clr0_row] <= 1'b0;
      end
      if (clr1) begin
        vld_q[clr1_row] <= 1'b0;
      end
      if (set) begin
        vld_q[set_row] <= 1'b1; // wins over a clear of the same row.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (set) begin
      bank_q[set_row] <= set_bank;
    end
  end

  assign look_vld0  = vld_q[look_row0];
  assign look_bank0 = bank_q[look_row0];
  assign look_vld1  = vld_q[look_row1];
  assign look_bank1 = bank_q[look_row1];

endmodule

`default_nettype wire

//--- hdl/port_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module port_scheduler
  import vbank_pkg::*;
(
  input  logic                       read,
  input  logic                       write0,
  input  logic [BITADDR-1:0]         addr0,
  input  logic [WIDTH-1:0]           din0,
  input  logic                       write1,
  input  logic [BITADDR-1:0]         addr1,
  input  logic [WIDTH-1:0]           din1,
  input  logic                       look_vld0,
  input  logic [BITVBNK-1:0]         look_bank0,
  input  logic                       look_vld1,
  input  logic [BITVBNK-1:0]         look_bank1,
  input  logic [WIDTH-1:0]           evict_data,
  output logic [NUMVBNK-1:0]         bank_read,
  output logic [NUMVBNK-1:0]         bank_write,
  output logic [NUMVBNK*BITVROW-1:0] bank_row,
  output logic [NUMVBNK*WIDTH-1:0]   bank_din,
  output logic                       cache_write,
  output logic [BITVROW-1:0]         cache_row,
  output logic [WIDTH-1:0]           cache_din,
  output logic                       map_set,
  output logic [BITVROW-1:0]         map_set_row,
  output logic [BITVBNK-1:0]         map_set_bank,
  output logic                       map_clr0,
  output logic [BITVROW-1:0]         map_clr0_row,
  output logic                       map_clr1,
  output logic [BITVROW-1:0]         map_clr1_row,
  output logic                       rd_issue,
  output logic                       rd_from_cache,
  output logic [BITVBNK-1:0]         rd_bank
);

  logic [BITVBNK-1:0] bank0;
  logic [BITVROW-1:0] row0;
  logic [BITVBNK-1:0] bank1;
  logic [BITVROW-1:0] row1;
  logic               hit0;
  logic               hit1;
  logic               rd_cache;
  logic               same_addr;
  logic               wr0_bank;
  logic               use0;
  logic               conflict;
  logic               evict;

  assign bank0 = addr0[BITADDR-1 -: BITVBNK];
  assign row0  = addr0[BITVROW-1:0];
  assign bank1 = addr1[BITADDR-1 -: BITVBNK];
  assign row1  = addr1[BITVROW-1:0];

  // cache row holds the newest copy of this port's own address.
  assign hit0 = look_vld0 && (look_bank0 == bank0);
  assign hit1 = look_vld1 && (look_bank1 == bank1);

  assign rd_cache  = read && hit0;
  assign same_addr = write0 && write1 && (addr0 == addr1); // port 1 wins.
  assign wr0_bank  = write0 && !same_addr;
  assign use0      = wr0_bank || (read && !rd_cache); // port 0 holds its bank.

  // port 1 is pushed into the cache when its bank is taken.
  assign conflict = write1 && use0 && (bank1 == bank0);

  // the displaced word goes home, its bank is never bank0.
  assign evict = conflict && look_vld1 && (look_bank1 != bank1);

  always_comb begin
    logic p0_wr;
    logic p1_wr;
    logic ev_wr;
    for (int b = 0; b < NUMVBNK; b++) begin
      p0_wr = wr0_bank && (bank0 == BITVBNK'(b));
      p1_wr = write1 && !conflict && (bank1 == BITVBNK'(b));
      ev_wr = evict && (look_bank1 == BITVBNK'(b));
      bank_read[b]  = read && !rd_cache && (bank0 == BITVBNK'(b));
      bank_write[b] = p0_wr || p1_wr || ev_wr;
      bank_row[b*BITVROW +: BITVROW] = (p1_wr || ev_wr) ? row1 : row0;
      if (p1_wr) begin
        bank_din[b*WIDTH +: WIDTH] = din1;
      end else if (ev_wr) begin
        bank_din[b*WIDTH +: WIDTH] = evict_data;
      end else begin
        bank_din[b*WIDTH +: WIDTH] = din0;
      end
    end
  end

  assign cache_write = conflict;
  assign cache_row   = row1;
  assign cache_din   = din1;

  assign map_set      = conflict;
  assign map_set_row  = row1;
  assign map_set_bank = bank1;

  // a direct bank write makes the cached copy stale.
  assign map_clr0     = wr0_bank && hit0;
  assign map_clr0_row = row0;
  assign map_clr1     = write1 && !conflict && hit1;
  assign map_clr1_row = row1;

  assign rd_issue      = read;
  assign rd_from_cache = rd_cache;
  assign rd_bank       = bank0;

endmodule

`default_nettype wire

//--- hdl/read_return.sv
`timescale 1ns/1ps
`default_nettype none

module read_return
  import vbank_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_issue,
  input  logic                     rd_from_cache,
  input  logic [BITVBNK-1:0]       rd_bank,
  input  logic [WIDTH-1:0]         cache_dout,
  input  logic [NUMVBNK*WIDTH-1:0] bank_dout,
  output logic                     rd_vld,
  output logic [WIDTH-1:0]         rd_dout
);

  logic [READ_DELAY-1:0] vld_q;
  logic [READ_DELAY-1:0] src_q;
  logic [BITVBNK-1:0]    bank_q [READ_DELAY];
  logic [WIDTH-1:0]      cdat_q [READ_DELAY];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= rd_issue;
      for (int i = 1; i < READ_DELAY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_issue) begin
      src_q[0]  <= rd_from_cache;
      bank_q[0] <= rd_bank;
      cdat_q[0] <= cache_dout; // cache word taken at issue time.
    end
    for (int i = 1; i < READ_DELAY; i++) begin
      src_q[i]  <= src_q[i-1];
      bank_q[i] <= bank_q[i-1];
      cdat_q[i] <= cdat_q[i-1];
    end
  end

  assign rd_vld  = vld_q[READ_DELAY-1];
  assign rd_dout = src_q[READ_DELAY-1] ? cdat_q[READ_DELAY-1] :
                   bank_dout[bank_q[READ_DELAY-1]*WIDTH +: WIDTH];

endmodule

`default_nettype wire

//--- hdl/vbank_mem_1rw1w.sv
`timescale 1ns/1ps
`default_nettype none

module vbank_mem_1rw1w
  import vbank_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               read,
  input  logic               write0,
  input  logic [BITADDR-1:0] addr0,
  input  logic [WIDTH-1:0]   din0,
  input  logic               write1,
  input  logic [BITADDR-1:0] addr1,
  input  logic [WIDTH-1:0]   din1,
  output logic               rd_vld,
  output logic [WIDTH-1:0]   rd_dout
);

  logic [NUMVBNK-1:0]         bank_read;
  logic [NUMVBNK-1:0]         bank_write;
  logic [NUMVBNK*BITVROW-1:0] bank_row;
  logic [NUMVBNK*WIDTH-1:0]   bank_din;
  logic [NUMVBNK*WIDTH-1:0]   bank_dout;
  logic                       cache_write;
  logic [BITVROW-1:0]         cache_row;
  logic [WIDTH-1:0]           cache_din;
  logic [WIDTH-1:0]           evict_data;
  logic [WIDTH-1:0]           cache_rd_data;
  logic                       map_set;
  logic [BITVROW-1:0]         map_set_row;
  logic [BITVBNK-1:0]         map_set_bank;
  logic                       map_clr0;
  logic [BITVROW-1:0]         map_clr0_row;
  logic                       map_clr1;
  logic [BITVROW-1:0]         map_clr1_row;
  logic                       look_vld0;
  logic [BITVBNK-1:0]         look_bank0;
  logic                       look_vld1;
  logic [BITVBNK-1:0]         look_bank1;
  logic                       rd_issue;
  logic                       rd_from_cache;
  logic [BITVBNK-1:0]         rd_bank;

  port_scheduler port_scheduler_inst (.*);

  map_table map_table_inst (
    .clk, .rst,
    .set (map_set), .set_row (map_set_row), .set_bank (map_set_bank),
    .clr0 (map_clr0), .clr0_row (map_clr0_row),
    .clr1 (map_clr1), .clr1_row (map_clr1_row),
    .look_row0 (addr0[BITVROW-1:0]), .look_row1 (addr1[BITVROW-1:0]),
    .look_vld0, .look_bank0, .look_vld1, .look_bank1
  );

  cache_bank cache_bank_inst (
    .clk,
    .write (cache_write), .wr_row (cache_row), .din (cache_din),
    .rd_row_a (addr1[BITVROW-1:0]), .rd_row_b (addr0[BITVROW-1:0]),
    .dout_a (evict_data), .dout_b (cache_rd_data)
  );

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    data_bank data_bank_inst (
      .clk, .rst,
      .read (bank_read[b]), .write (bank_write[b]),
      .row (bank_row[b*BITVROW +: BITVROW]),
      .din (bank_din[b*WIDTH +: WIDTH]),
      .dout (bank_dout[b*WIDTH +: WIDTH])
    );
  end

  read_return read_return_inst (
    .clk, .rst, .rd_issue, .rd_from_cache, .rd_bank,
    .cache_dout (cache_rd_data), .bank_dout,
    .rd_vld, .rd_dout
  );

endmodule

`default_nettype wire

//--- hdl/vbank_pkg.sv
`default_nettype none

package vbank_pkg;

  // data word
  localparam int WIDTH = 8;

  // banks and their index
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;

  // rows per bank and their index
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;

  // logical space, bank in the upper bits, row in the lower.
  localparam int NUMADDR = NUMVBNK * NUMVROW;
  localparam int BITADDR = BITVBNK + BITVROW;

  // read request to returned word, also the bank read latency.
  localparam int READ_DELAY = 2;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_vbank_mem \
  -o tb_vbank_mem || { echo "build failed"; exit 1; }
./obj_dir/tb_vbank_mem > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || { echo "no pass line in the log"; exit 1; }
exit 0

//--- include/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// stops the run at the first mismatch.
task automatic check_value(input string name, input logic [WIDTH-1:0] got,
                           input logic [WIDTH-1:0] exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
    $display(">>> FAIL");
    $fatal(1, "%s mismatch", name);
  end
endtask

// compares one returned word, called right after the read is driven.
task automatic check_word(input logic [BITADDR-1:0] addr, input logic [WIDTH-1:0] exp);
  repeat (READ_DELAY + 1) @(posedge clk);
  check_value("rd_vld", WIDTH'(rd_vld), WIDTH'(1'b1));
  check_value($sformatf("rd_dout of addr %0d", addr), rd_dout, exp);
endtask

// one cycle on both ports, the model follows with port 1 applied last.
task automatic drive(input logic rd, input logic w0, input logic [BITADDR-1:0] a0,
                     input logic [WIDTH-1:0] d0, input logic w1,
                     input logic [BITADDR-1:0] a1, input logic [WIDTH-1:0] d1);
  logic [WIDTH-1:0] exp;
  @(posedge clk);
  read   <= rd;
  write0 <= w0;
  addr0  <= a0;
  din0   <= d0;
  write1 <= w1;
  addr1  <= a1;
  din1   <= d1;
  if (rd) begin
    exp = ref_mem[a0]; // old word even with a same-cycle write.
    fork
      check_word(a0, exp);
    join_none
  end
  if (w0) ref_mem[a0] = d0;
  if (w1) ref_mem[a1] = d1;
endtask

task automatic idle(input int cycles);
  repeat (cycles) drive(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
endtask

task automatic wr0(input logic [BITADDR-1:0] a, input logic [WIDTH-1:0] d);
  drive(1'b0, 1'b1, a, d, 1'b0, '0, '0);
endtask

task automatic rd0(input logic [BITADDR-1:0] a);
  drive(1'b1, 1'b0, a, '0, 1'b0, '0, '0);
endtask

`endif

//--- tests/tb_vbank_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vbank_mem
  import vbank_pkg::*;
();

  logic               clk;
  logic               rst;
  logic               read;
  logic               write0;
  logic [BITADDR-1:0] addr0;
  logic [WIDTH-1:0]   din0;
  logic               write1;
  logic [BITADDR-1:0] addr1;
  logic [WIDTH-1:0]   din1;
  logic               rd_vld;
  logic [WIDTH-1:0]   rd_dout;

  logic [WIDTH-1:0]      ref_mem [NUMADDR]; // expected memory contents.
  logic [READ_DELAY-1:0] issue_hist;        // reads accepted in the last cycles.
  int                    cycle_count = 0;

  vbank_mem_1rw1w vbank_mem_1rw1w_inst (.*);

  `include "tb_tasks.svh"

  function automatic logic [BITADDR-1:0] addr_of(input int bank, input int row);
    return {BITVBNK'(bank), BITVROW'(row)};
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // rd_vld must follow every accepted read by READ_DELAY cycles and never pulse otherwise.
  always @(posedge clk) begin
    if (rst) begin
      issue_hist <= '0;
    end else begin
      issue_hist <= {issue_hist[READ_DELAY-2:0], read};
      check_value("rd_vld", WIDTH'(rd_vld), WIDTH'(issue_hist[READ_DELAY-1]));
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == 4000) begin // well above the length of all tests.
      $display("timeout, the run did not finish within %0d cycles", cycle_count);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic basic_write_read();
    idle(4); // rd_vld has to stay low here.
    wr0(addr_of(1, 3), 8'h5a);
    rd0(addr_of(1, 3));
    idle(READ_DELAY + 1);
    wr0(addr_of(2, 0), 8'ha5);
    rd0(addr_of(2, 0));
    rd0(addr_of(1, 3));
    idle(READ_DELAY + 1);
  endtask

  task automatic split_bank_writes();
    drive(1'b0, 1'b1, addr_of(2, 4), 8'h11, 1'b1, addr_of(2, 9), 8'h22);
    drive(1'b0, 1'b1, addr_of(0, 1), 8'h33, 1'b1, addr_of(3, 1), 8'h44);
    rd0(addr_of(2, 4));
    rd0(addr_of(2, 9)); // comes back through the cache.
    rd0(addr_of(0, 1));
    rd0(addr_of(3, 1));
    idle(READ_DELAY + 1);
  endtask

  task automatic cache_eviction();
    for (int i = 0; i < 6; i++) begin
      drive(1'b0, 1'b1, addr_of(i % NUMVBNK, i), WIDTH'(8'h30 + i),
            1'b1, addr_of(i % NUMVBNK, 7), WIDTH'(8'h80 + i));
    end
    // a port 0 read on the bank also pushes port 1 into the cache.
    drive(1'b1, 1'b0, addr_of(2, 2), '0, 1'b1, addr_of(2, 7), 8'h9f);
    for (int b = 0; b < NUMVBNK; b++) begin
      rd0(addr_of(b, 7));
    end
    for (int i = 0; i < 6; i++) begin
      rd0(addr_of(i % NUMVBNK, i));
    end
    idle(READ_DELAY + 1);
  endtask

  task automatic read_old_word();
    wr0(addr_of(3, 5), 8'haa);
    wr0(addr_of(3, 6), 8'hbb);
    drive(1'b1, 1'b0, addr_of(3, 5), '0, 1'b1, addr_of(3, 5), 8'hcc); // old word back.
    drive(1'b1, 1'b0, addr_of(3, 6), '0, 1'b1, addr_of(3, 9), 8'hdd);
    drive(1'b1, 1'b0, addr_of(3, 5), '0, 1'b1, addr_of(3, 6), 8'hee);
    rd0(addr_of(3, 5));
    rd0(addr_of(3, 6));
    rd0(addr_of(3, 9));
    idle(READ_DELAY + 1);
  endtask

  task automatic same_address_writes();
    drive(1'b0, 1'b1, addr_of(0, 12), 8'h01, 1'b1, addr_of(0, 12), 8'h02);
    rd0(addr_of(0, 12));
    drive(1'b0, 1'b1, addr_of(0, 11), 8'h05, 1'b1, addr_of(0, 12), 8'h03);
    drive(1'b0, 1'b1, addr_of(0, 12), 8'h06, 1'b1, addr_of(0, 12), 8'h07);
    rd0(addr_of(0, 12));
    rd0(addr_of(0, 11));
    idle(READ_DELAY + 1);
  endtask

  task automatic random_traffic(input int cycles);
    int unsigned        mode;
    logic               w1;
    logic [BITADDR-1:0] a0;
    logic [BITADDR-1:0] a1;
    for (int a = 0; a < NUMADDR; a++) begin
      wr0(BITADDR'(a), WIDTH'($urandom));
    end
    repeat (cycles) begin
      mode = $urandom % 3;
      w1   = 1'($urandom % 2);
      a0   = BITADDR'($urandom);
      if ($urandom % 2 == 0) begin
        a1 = {a0[BITADDR-1 -: BITVBNK], BITVROW'($urandom)}; // same bank, mostly collides.
      end else begin
        a1 = BITADDR'($urandom);
      end
      drive(mode == 1, mode == 2, a0, WIDTH'($urandom), w1, a1, WIDTH'($urandom));
    end
    idle(READ_DELAY + 1);
  endtask

  initial begin
    rst    <= 1'b1;
    read   <= 1'b0;
    write0 <= 1'b0;
    addr0  <= '0;
    din0   <= '0;
    write1 <= 1'b0;
    addr1  <= '0;
    din1   <= '0;
    void'($urandom(68));
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    basic_write_read();
    split_bank_writes();
    cache_eviction();
    read_old_word();
    same_address_writes();
    random_traffic(500);
    idle(READ_DELAY + 2);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/vbank_mem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module vbank_mem_assertions
  import vbank_pkg::*;
(
  input logic               clk,
  input logic               rst,
  input logic               read,
  input logic               write0,
  input logic [BITADDR-1:0] addr0,
  input logic [BITADDR-1:0] addr1,
  input logic [NUMVBNK-1:0] bank_read,
  input logic [NUMVBNK-1:0] bank_write,
  input logic               cache_write,
  input logic               look_vld0,
  input logic [BITVBNK-1:0] look_bank0,
  input logic               look_vld1,
  input logic [BITVBNK-1:0] look_bank1
);

  logic [BITVBNK-1:0] bank0;
  logic [BITVBNK-1:0] bank1;
  logic               evict;

  assign bank0 = addr0[BITADDR-1 -: BITVBNK];
  assign bank1 = addr1[BITADDR-1 -: BITVBNK];
  assign evict = cache_write && look_vld1 && (look_bank1 != bank1); // old word goes home.

  bank_one_op: assert property (@(posedge clk) disable iff (rst)
    (bank_read & bank_write) == '0)
    else $error("a bank got a read and a write in one cycle");

  port0_one_op: assert property (@(posedge clk) disable iff (rst) !(read && write0))
    else $error("read and write0 asserted together");

  evict_free_bank: assert property (@(posedge clk) disable iff (rst)
    evict |-> (look_bank1 != bank0))
    else $error("eviction targets the bank in use by port 0");

  // only a read whose word is not held in the cache touches a bank, and only its own.
  bank_read_source: assert property (@(posedge clk) disable iff (rst)
    (|bank_read) |-> (read && !(look_vld0 && (look_bank0 == bank0)) &&
                      (bank_read == (NUMVBNK'(1) << bank0))))
    else $error("bank read without a port 0 read of a word held in that bank");

endmodule

bind vbank_mem_1rw1w vbank_mem_assertions vbank_mem_assertions_inst (
  .clk, .rst, .read, .write0, .addr0, .addr1,
  .bank_read, .bank_write, .cache_write,
  .look_vld0, .look_bank0, .look_vld1, .look_bank1
);

`default_nettype wire
